// ==== src.f ====
hw/scan_harness_pkg.sv
hw/scan_in_reg.sv
hw/scan_out_reg.sv
hw/key_scanner.sv
hw/lcd_writer.sv
hw/uart_tx.sv
hw/panel_core.sv
hw/self_test.sv
hw/scan_harness_top.sv
verification/scan_harness_tb.sv

// ==== verification/scan_harness_tb.sv ====
//////////////////////////////////////////////////
// table-driven testbench for the scan harness.
// per row: shift words into every unit, settle,
// load, shift the results out and compare them.
// self-test pins are watched in a parallel block
//////////////////////////////////////////////////
`timescale 1ns/1ps

module scan_harness_tb;

    localparam int NUM_UNITS      = 6;
    localparam int SELFTEST_CYC   = 64;
    localparam int WORD_W         = 18;
    localparam int NUM_ROWS       = 5;
    localparam int SETTLE_CYCLES  = 64;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 120 + 200;

    logic                 clk;
    logic                 arst_n;
    logic                 shift;
    logic                 load;
    logic [NUM_UNITS-1:0] sdi;
    logic [NUM_UNITS-1:0] sdo;
    logic                 pass;
    logic                 done;
    logic                 clkout;

    //////////////////////////////////////////////////
    // stimulus and expected values, row by unit
    string      row_name [NUM_ROWS];
    logic       use_scan [NUM_ROWS];
    logic       check_y  [NUM_ROWS];
    logic [4:0] t_key_x  [NUM_ROWS][NUM_UNITS];
    logic       t_busy   [NUM_ROWS][NUM_UNITS];
    logic       t_cts_n  [NUM_ROWS][NUM_UNITS];
    logic       t_rs     [NUM_ROWS][NUM_UNITS];
    logic       t_rw     [NUM_ROWS][NUM_UNITS];
    logic       t_e      [NUM_ROWS][NUM_UNITS];
    logic [7:0] t_dbo    [NUM_ROWS][NUM_UNITS];
    logic       t_txd    [NUM_ROWS][NUM_UNITS];
    logic       t_rts    [NUM_ROWS][NUM_UNITS];

    logic [WORD_W-1:0] in_word  [NUM_UNITS];
    logic [WORD_W-1:0] out_word [NUM_UNITS];

    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;
    logic        row_bad;
    logic        selftest_checked = 1'b0;
    logic        st_bad;
    logic        exp_clkout;
    int unsigned seed;
    int unsigned rnd;

    scan_harness_top scan_harness_top_i (
        .clk    (clk),
        .arst_n (arst_n),
        .shift  (shift),
        .load   (load),
        .sdi    (sdi),
        .sdo    (sdo),
        .pass   (pass),
        .done   (done),
        .clkout (clkout)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    task automatic set_entry(input int r, input int u, input logic [4:0] kx,
                             input logic busy, input logic cts_n, input logic rs,
                             input logic rw, input logic e, input logic [7:0] dbo,
                             input logic txd, input logic rts);
        t_key_x[r][u] = kx;
        t_busy[r][u]  = busy;
        t_cts_n[r][u] = cts_n;
        t_rs[r][u]    = rs;
        t_rw[r][u]    = rw;
        t_e[r][u]     = e;
        t_dbo[r][u]   = dbo;
        t_txd[r][u]   = txd;
        t_rts[r][u]   = rts;
    endtask

    task automatic fill_table();
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            use_scan[r] = 1'b1;
            check_y[r]  = 1'b1;
        end
        // read back straight after reset, no input shifted
        row_name[0] = "reset values";
        use_scan[0] = 1'b0;
        for (int u = 0; u < NUM_UNITS; u++)
            set_entry(0, u, 5'b11111, 0, 1, 0, 0, 0, 8'h00, 1, 0);
        // one column per unit, unit 5 holds columns 2 and 4
        row_name[1] = "one column per unit";
        set_entry(1, 0, 5'b11110, 0, 0, 1, 0, 0, "1", 1, 0);
        set_entry(1, 1, 5'b11101, 0, 0, 1, 0, 0, "2", 1, 0);
        set_entry(1, 2, 5'b11011, 0, 0, 1, 0, 0, "3", 1, 0);
        set_entry(1, 3, 5'b10111, 0, 0, 1, 0, 0, "4", 1, 0);
        set_entry(1, 4, 5'b01111, 0, 0, 1, 0, 0, "5", 1, 0);
        set_entry(1, 5, 5'b01011, 0, 0, 1, 0, 0, "3", 1, 0);
        // unit 0 stuck polling busy, unit 1 byte pending on cts
        row_name[2] = "lcd busy and cts high";
        set_entry(2, 0, 5'b10111, 1, 0, 0, 1, 1, "1", 1, 0);
        set_entry(2, 1, 5'b11110, 0, 1, 1, 0, 0, "1", 1, 1);
        set_entry(2, 2, 5'b11011, 0, 0, 1, 0, 0, "3", 1, 0);
        set_entry(2, 3, 5'b10111, 0, 0, 1, 0, 0, "4", 1, 0);
        set_entry(2, 4, 5'b01111, 0, 0, 1, 0, 0, "5", 1, 0);
        set_entry(2, 5, 5'b01011, 0, 0, 1, 0, 0, "3", 1, 0);
        // busy cleared and cts low, same keys held
        row_name[3] = "busy cleared and cts low";
        set_entry(3, 0, 5'b10111, 0, 0, 1, 0, 0, "4", 1, 0);
        set_entry(3, 1, 5'b11110, 0, 0, 1, 0, 0, "1", 1, 0);
        set_entry(3, 2, 5'b11011, 0, 0, 1, 0, 0, "3", 1, 0);
        set_entry(3, 3, 5'b10111, 0, 0, 1, 0, 0, "4", 1, 0);
        set_entry(3, 4, 5'b01111, 0, 0, 1, 0, 0, "5", 1, 0);
        set_entry(3, 5, 5'b01011, 0, 0, 1, 0, 0, "3", 1, 0);
        // release, lcd keeps the last character
        row_name[4] = "keys released";
        set_entry(4, 0, 5'b11111, 0, 0, 1, 0, 0, "4", 1, 0);
        set_entry(4, 1, 5'b11111, 0, 0, 1, 0, 0, "1", 1, 0);
        set_entry(4, 2, 5'b11111, 0, 0, 1, 0, 0, "3", 1, 0);
        set_entry(4, 3, 5'b11111, 0, 0, 1, 0, 0, "4", 1, 0);
        set_entry(4, 4, 5'b11111, 0, 0, 1, 0, 0, "5", 1, 0);
        set_entry(4, 5, 5'b11111, 0, 0, 1, 0, 0, "3", 1, 0);
    endtask

    // reserved 17:15 high, rxd and dbi 6:0 random
    task automatic build_words(input int r);
        for (int u = 0; u < NUM_UNITS; u++)
        begin
            rnd = $urandom;
            in_word[u] = {3'b111, t_cts_n[r][u], rnd[7], t_key_x[r][u],
                          t_busy[r][u], rnd[6:0]};
        end
    endtask

    // msb first into every unit at once
    task automatic shift_words();
        logic [NUM_UNITS-1:0] bits;
        for (int b = WORD_W - 1; b >= 0; b--)
        begin
            for (int u = 0; u < NUM_UNITS; u++)
                bits[u] = in_word[u][b];
            @(posedge clk);
            shift <= 1'b1;
            sdi   <= bits;
        end
        @(posedge clk);
        shift <= 1'b0;
        sdi   <= '1;
    endtask

    // load, then sample sdo mid-cycle before each shift edge
    task automatic read_words();
        @(posedge clk);
        load <= 1'b1;
        @(posedge clk);
        load  <= 1'b0;
        shift <= 1'b1;
        sdi   <= '1;
        for (int b = WORD_W - 1; b >= 0; b--)
        begin
            @(negedge clk);
            for (int u = 0; u < NUM_UNITS; u++)
                out_word[u][b] = sdo[u];
            @(posedge clk);
        end
        shift <= 1'b0;
    endtask

    task automatic compare_field(input int u, input string name, input logic [7:0] exp,
                                 input logic [7:0] got);
        if (got !== exp)
        begin
            $display("** Error at %0t: unit %0d %s expected 'h%02h, got 'h%02h",
                     $time, u, name, exp, got);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // output word: 0 rs, 1 rw, 2 e, 10:3 dbo,
    // 15:11 key_y, 16 txd, 17 rts
    task automatic check_row(input int r);
        logic [4:0] key_y;
        int         lows;
        for (int u = 0; u < NUM_UNITS; u++)
        begin
            compare_field(u, "lcd_rs", t_rs[r][u], out_word[u][0]);
            compare_field(u, "lcd_rw", t_rw[r][u], out_word[u][1]);
            compare_field(u, "lcd_e", t_e[r][u], out_word[u][2]);
            compare_field(u, "lcd_dbo", t_dbo[r][u], out_word[u][10:3]);
            compare_field(u, "txd", t_txd[r][u], out_word[u][16]);
            compare_field(u, "rts", t_rts[r][u], out_word[u][17]);
            key_y = out_word[u][15:11];
            lows  = 0;
            for (int i = 0; i < 5; i++)
            begin
                if (key_y[i] === 1'b0)
                    lows++;
            end
            if (check_y[r] && lows != 1)
            begin
                $display("** Error at %0t: unit %0d key_y %05b should have one low bit",
                         $time, u, key_y);
                errors++;
                row_bad = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // self-test pins, k counts edges since release
    initial
    begin
        st_bad = 1'b0;
        @(posedge arst_n);
        for (int k = 1; k <= SELFTEST_CYC + 4; k++)
        begin
            @(posedge clk);
            @(negedge clk);
            // clk / 4 from a low reset value
            exp_clkout = ((k / 2) % 2) != 0;
            if (clkout !== exp_clkout)
            begin
                $display("** Error at %0t: clkout expected %b, got %b",
                         $time, exp_clkout, clkout);
                st_bad = 1'b1;
            end
            if (done !== (k >= SELFTEST_CYC))
            begin
                $display("** Error at %0t: done expected %b, got %b",
                         $time, k >= SELFTEST_CYC, done);
                st_bad = 1'b1;
            end
            if (k >= SELFTEST_CYC && pass !== 1'b1)
            begin
                $display("** Error at %0t: pass expected 1, got %b", $time, pass);
                st_bad = 1'b1;
            end
        end
        tests_run++;
        if (st_bad)
        begin
            errors++;
            tests_failed++;
        end
        $display("self-test done, pass and clkout: %s", st_bad ? "mismatch" : "ok");
        selftest_checked = 1'b1;
    end

    // hard stop on a stuck run
    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        seed   = 32'h9d03_c321;
        rnd    = $urandom(seed);
        arst_n = 1'b0;
        shift  = 1'b0;
        load   = 1'b0;
        sdi    = '0;
        fill_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row_bad = 1'b0;
            if (use_scan[r])
            begin
                build_words(r);
                shift_words();
                repeat (SETTLE_CYCLES) @(posedge clk);
            end
            read_words();
            check_row(r);
            tests_run++;
            if (row_bad)
                tests_failed++;
            $display("row %0d %s: %s", r, row_name[r], row_bad ? "mismatch" : "ok");
        end

        if (!selftest_checked)
        begin
            $display("self-test check never completed");
            tests_run++;
            tests_failed++;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== hw/scan_harness_top.sv ====
//////////////////////////////////////////////////
// multi-unit scan harness: per unit an input
// chain, a panel core and an output chain, plus
// one shared self-test block
//////////////////////////////////////////////////
`timescale 1ns/1ps

module scan_harness_top
    import scan_harness_pkg::*;
#(
    parameter int NUM_UNITS       = 6,
    parameter int DEBOUNCE        = 4,
    parameter int E_WIDTH         = 2,
    parameter int BAUD_DIV        = 4,
    parameter int SELFTEST_CYCLES = 64
)
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 shift,
    input  logic                 load,
    input  logic [NUM_UNITS-1:0] sdi,
    output logic [NUM_UNITS-1:0] sdo,
    output logic                 pass,
    output logic                 done,
    output logic                 clkout
);

    word_t core_in  [NUM_UNITS];
    word_t core_out [NUM_UNITS];

    self_test #(.SELFTEST_CYCLES(SELFTEST_CYCLES)) self_test_i (
        .clk    (clk),
        .arst_n (arst_n),
        .pass   (pass),
        .done   (done),
        .clkout (clkout)
    );

    //////////////////////////////////////////////////
    // one chain pair and core per unit
    for (genvar u = 0; u < NUM_UNITS; u++)
    begin : g_unit
        scan_in_reg scan_in_reg_i (
            .clk    (clk),
            .arst_n (arst_n),
            .shift  (shift),
            .sdi    (sdi[u]),
            .word   (core_in[u])
        );

        panel_core #(
            .DEBOUNCE (DEBOUNCE),
            .E_WIDTH  (E_WIDTH),
            .BAUD_DIV (BAUD_DIV)
        ) panel_core_i (
            .clk      (clk),
            .arst_n   (arst_n),
            .word_in  (core_in[u]),
            .word_out (core_out[u])
        );

        scan_out_reg scan_out_reg_i (
            .clk    (clk),
            .arst_n (arst_n),
            .shift  (shift),
            .load   (load),
            .word   (core_out[u]),
            .sdo    (sdo[u])
        );
    end

endmodule

// ==== hw/self_test.sv ====
//////////////////////////////////////////////////
// post-reset self-test: steps a 16-bit lfsr for
// SELFTEST_CYCLES cycles, checks the signature,
// and emits clk divided by 4
//////////////////////////////////////////////////
`timescale 1ns/1ps

module self_test
    import scan_harness_pkg::*;
#(
    parameter int SELFTEST_CYCLES = 64
)
(
    input  logic clk,
    input  logic arst_n,
    output logic pass,
    output logic done,
    output logic clkout
);

    localparam int CNT_W = $clog2(SELFTEST_CYCLES + 1);

    lfsr_t            lfsr;
    logic [CNT_W-1:0] cycle_cnt;
    logic [1:0]       div;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lfsr      <= SELFTEST_SEED;
            cycle_cnt <= '0;
            done      <= 1'b0;
            div       <= '0;
        end
        else
        begin
            div <= div + 1'b1;
            // lfsr frozen once done
            if (!done)
            begin
                // taps 16,14,13,11, new bit into the msb
                lfsr      <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[LFSR_W-1:1]};
                cycle_cnt <= cycle_cnt + 1'b1;
                if (cycle_cnt == CNT_W'(SELFTEST_CYCLES - 1))
                    done <= 1'b1;
            end
        end
    end

    assign pass   = done && (lfsr == SELFTEST_GOLDEN);
    // toggles every 2 cycles
    assign clkout = div[1];

endmodule

// ==== hw/panel_core.sv ====
//////////////////////////////////////////////////
// one unit's panel core: unpacks the scan word,
// runs keypad, lcd and uart, packs the result
//////////////////////////////////////////////////
`timescale 1ns/1ps

module panel_core
    import scan_harness_pkg::*;
#(
    parameter int DEBOUNCE = 4,
    parameter int E_WIDTH  = 2,
    parameter int BAUD_DIV = 4
)
(
    input  logic  clk,
    input  logic  arst_n,
    input  word_t word_in,
    output word_t word_out
);

    key_lines_t key_y;
    logic       key_new;
    key_code_t  key_code;

    // keypad, valid flag not needed at this level
    key_scanner #(.DEBOUNCE(DEBOUNCE)) key_scanner_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_x     (word_in[KEY_X_MSB:KEY_X_LSB]),
        .key_y     (key_y),
        .key_valid (),
        .key_new   (key_new),
        .key_code  (key_code)
    );

    // same key event feeds both peripherals
    lcd_writer #(.E_WIDTH(E_WIDTH)) lcd_writer_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (key_new),
        .char_in (key_code),
        .lcd_dbi (word_in[LCD_DBI_MSB:LCD_DBI_LSB]),
        .lcd_rs  (word_out[LCD_RS_BIT]),
        .lcd_rw  (word_out[LCD_RW_BIT]),
        .lcd_e   (word_out[LCD_E_BIT]),
        .lcd_dbo (word_out[LCD_DBO_MSB:LCD_DBO_LSB])
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV)) uart_tx_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (key_new),
        .data   (key_code),
        .cts_n  (word_in[CTS_N_BIT]),
        .txd    (word_out[TXD_BIT]),
        .rts    (word_out[RTS_BIT])
    );

    assign word_out[KEY_Y_MSB:KEY_Y_LSB] = key_y;

endmodule

// ==== hw/uart_tx.sv ====
//////////////////////////////////////////////////
// 8n1 uart transmitter, byte latched on start,
// rts flags a pending byte, frame waits for cts
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx
    import scan_harness_pkg::*;
#(
    parameter int BAUD_DIV = 4
)
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  key_code_t data,
    input  logic      cts_n,
    output logic      txd,
    output logic      rts
);

    localparam int BAUD_W = $clog2(BAUD_DIV + 1);

    uart_state_t       state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    key_code_t         shreg;
    logic              baud_end;

    assign baud_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            // counter runs per bit time, cleared between bits
            if (state == TX_IDLE || state == TX_WAIT_CTS || baud_end)
                baud_cnt <= '0;
            else
                baud_cnt <= baud_cnt + 1'b1;

            case (state)
                TX_IDLE:
                begin
                    if (start)
                        state <= TX_WAIT_CTS;
                end
                TX_WAIT_CTS:
                begin
                    if (!cts_n)
                        state <= TX_START;
                end
                TX_START:
                begin
                    if (baud_end)
                    begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                    end
                end
                TX_DATA:
                begin
                    if (baud_end)
                    begin
                        if (bit_cnt == 3'd7)
                            state <= TX_STOP;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                TX_STOP:
                begin
                    if (baud_end)
                        state <= TX_IDLE;
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // lsb first, key_new while busy is dropped
    always_ff @(posedge clk)
    begin
        if (state == TX_IDLE && start)
            shreg <= data;
        else if (state == TX_DATA && baud_end)
            shreg <= shreg >> 1;
    end

    assign txd = (state == TX_START) ? 1'b0 :
                 (state == TX_DATA)  ? shreg[0] : 1'b1;
    assign rts = (state != TX_IDLE);

endmodule

// ==== hw/lcd_writer.sv ====
//////////////////////////////////////////////////
// character lcd writer: polls the busy flag, then
// drives one data write with a stretched enable
// and keeps the last character on the bus
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lcd_writer
    import scan_harness_pkg::*;
#(
    parameter int E_WIDTH = 2
)
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  key_code_t char_in,
    input  lcd_data_t lcd_dbi,
    output logic      lcd_rs,
    output logic      lcd_rw,
    output logic      lcd_e,
    output lcd_data_t lcd_dbo
);

    localparam int E_CNT_W = $clog2(E_WIDTH + 1);

    lcd_state_t         state;
    logic [E_CNT_W-1:0] e_cnt;
    key_code_t          char_q;
    logic               busy;
    logic               accept;

    // busy flag on db7 during a status read
    assign busy   = lcd_dbi[LCD_DATA_W-1];
    // new characters only between writes
    assign accept = start && (state == LCD_IDLE || state == LCD_HOLD);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= LCD_IDLE;
            e_cnt   <= '0;
            lcd_dbo <= '0;
        end
        else
        begin
            case (state)
                LCD_IDLE, LCD_HOLD:
                begin
                    if (accept)
                        state <= LCD_POLL;
                end
                LCD_POLL:
                begin
                    if (!busy)
                    begin
                        state   <= LCD_WRITE;
                        e_cnt   <= '0;
                        lcd_dbo <= char_q;
                    end
                end
                LCD_WRITE:
                begin
                    // enable high for E_WIDTH cycles
                    if (e_cnt == E_CNT_W'(E_WIDTH - 1))
                        state <= LCD_HOLD;
                    else
                        e_cnt <= e_cnt + 1'b1;
                end
                default:
                    state <= LCD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            char_q <= char_in;
    end

    // bus control per state
    assign lcd_rs = (state == LCD_WRITE) || (state == LCD_HOLD);
    assign lcd_rw = (state == LCD_POLL);
    assign lcd_e  = (state == LCD_POLL) || (state == LCD_WRITE);

endmodule

// ==== hw/key_scanner.sv ====
//////////////////////////////////////////////////
// keypad row walker and column debouncer, latches
// the ascii digit of the lowest low column
//////////////////////////////////////////////////
`timescale 1ns/1ps

module key_scanner
    import scan_harness_pkg::*;
#(
    parameter int DEBOUNCE = 4
)
(
    input  logic       clk,
    input  logic       arst_n,
    input  key_lines_t key_x,
    output key_lines_t key_y,
    output logic       key_valid,
    output logic       key_new,
    output key_code_t  key_code
);

    localparam int CNT_W = $clog2(DEBOUNCE + 1);

    key_lines_t       x_prev;
    logic [CNT_W-1:0] stable_cnt;
    logic             stable;
    logic             report;
    key_code_t        enc_code;

    assign stable = (stable_cnt == CNT_W'(DEBOUNCE));
    // pulse on the first stable cycle
    // any code change restarts the debounce first
    assign report = stable && !key_valid;

    // priority encoder, lowest index wins
    always_comb
    begin
        enc_code = KEY_CODE_BASE;
        for (int i = KEY_LINES_W - 1; i >= 0; i--)
        begin
            if (!x_prev[i])
                enc_code = KEY_CODE_BASE + key_code_t'(i);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_y      <= 5'b11110;
            x_prev     <= '1;
            stable_cnt <= '0;
            key_valid  <= 1'b0;
            key_new    <= 1'b0;
        end
        else
        begin
            x_prev <= key_x;
            // walk rows only while every column is idle
            if (&key_x)
                key_y <= {key_y[KEY_LINES_W-2:0], key_y[KEY_LINES_W-1]};
            // restart on change or release, saturate at DEBOUNCE
            if (key_x != x_prev || &key_x)
                stable_cnt <= '0;
            else if (!stable)
                stable_cnt <= stable_cnt + 1'b1;
            key_valid <= stable;
            key_new   <= report;
        end
    end

    // code survives release
    always_ff @(posedge clk)
    begin
        if (report)
            key_code <= enc_code;
    end

endmodule

// ==== hw/scan_out_reg.sv ====
//////////////////////////////////////////////////
// parallel-load serial-out chain for one unit's
// output word, load wins over shift, msb first
//////////////////////////////////////////////////
`timescale 1ns/1ps

module scan_out_reg
    import scan_harness_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  shift,
    input  logic  load,
    input  word_t word,
    output logic  sdo
);

    word_t sr;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sr <= '0;
        end
        else if (load)
        begin
            sr <= word;
        end
        else if (shift)
        begin
            // move toward the msb, zero fill
            sr <= {sr[WORD_W-2:0], 1'b0};
        end
    end

    // msb visible right after load
    assign sdo = sr[WORD_W-1];

endmodule

// ==== hw/scan_in_reg.sv ====
//////////////////////////////////////////////////
// serial-in parallel-out chain for one unit's
// input word, msb first, holds while shift is low
//////////////////////////////////////////////////
`timescale 1ns/1ps

module scan_in_reg
    import scan_harness_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  shift,
    input  logic  sdi,
    output word_t word
);

    // new bit enters at bit 0, first bit sent ends at the msb
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            word <= '0;
        end
        else if (shift)
        begin
            word <= {word[WORD_W-2:0], sdi};
        end
    end

endmodule

// ==== hw/scan_harness_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, word bit positions, FSM states
// and the self-test signature for the harness.
// import with scan_harness_pkg::* where needed
//////////////////////////////////////////////////
package scan_harness_pkg;

    // word and bus widths
    localparam int WORD_W      = 18;
    localparam int LCD_DATA_W  = 8;
    localparam int KEY_LINES_W = 5;
    localparam int KEY_CODE_W  = 8;
    localparam int LFSR_W      = 16;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [LCD_DATA_W-1:0]  lcd_data_t;
    // rows and columns, active low
    typedef logic [KEY_LINES_W-1:0] key_lines_t;
    // ascii digit of the pressed column
    typedef logic [KEY_CODE_W-1:0]  key_code_t;
    typedef logic [LFSR_W-1:0]      lfsr_t;

    // column 0 reports '1'
    localparam key_code_t KEY_CODE_BASE = 8'h31;

    //////////////////////////////////////////////////
    // input word, bit 13 (rxd) and 17:15 reserved
    localparam int LCD_DBI_LSB = 0;
    localparam int LCD_DBI_MSB = 7;
    localparam int KEY_X_LSB   = 8;
    localparam int KEY_X_MSB   = 12;
    localparam int CTS_N_BIT   = 14;

    //////////////////////////////////////////////////
    // output word
    localparam int LCD_RS_BIT  = 0;
    localparam int LCD_RW_BIT  = 1;
    localparam int LCD_E_BIT   = 2;
    localparam int LCD_DBO_LSB = 3;
    localparam int LCD_DBO_MSB = 10;
    localparam int KEY_Y_LSB   = 11;
    localparam int KEY_Y_MSB   = 15;
    localparam int TXD_BIT     = 16;
    localparam int RTS_BIT     = 17;

    typedef enum logic [1:0] {LCD_IDLE, LCD_POLL, LCD_WRITE, LCD_HOLD} lcd_state_t;
    typedef enum logic [2:0] {TX_IDLE, TX_WAIT_CTS, TX_START, TX_DATA, TX_STOP} uart_state_t;

    // lfsr taps 16,14,13,11 shifting right, 64 steps from the seed
    localparam lfsr_t SELFTEST_SEED   = 16'hACE1;
    localparam lfsr_t SELFTEST_GOLDEN = 16'h8815;

endpackage
